/* sim/tacho_trace.txt */
# T name | W addr data | R addr expected | M channel period lag pulses
# numbers in hex, channel 0 is spd_ch[0], pulses 0 means free running
T id_regs
R 800 B616
R 802 AAAA
R 804 5555
T readback
W 810 0003
W 812 000F
W 826 ABCD
W 844 8765
W 862 0101
W 814 0002
R 810 0003
R 812 000F
R 826 ABCD
R 844 8765
R 862 0101
R 814 0000
T free_run
W 810 0000
W 820 0005
W 822 0000
W 840 0003
W 842 0000
W 814 0001
M 0 A 3 0
T lead_flag
W 840 0007
W 842 8000
W 814 0001
M 1 A 7 0
T limited
W 810 0001
W 840 0003
W 842 0000
W 860 0003
W 814 0001
M 0 A 3 3
R 870 0001
T disabled
W 812 0007
W 824 0004
W 826 0000
W 844 0002
W 814 0002
M 3 0 0 0

/* compile.f */
+incdir+include
rtl/bus_pkg.sv
rtl/tacho_pkg.sv
rtl/local_bus_sync.sv
rtl/tacho_regs.sv
rtl/tacho_pair.sv
rtl/sim_db_top.sv
sim/tb_sim_db.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, verdict from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f compile.f --top-module tb_sim_db --Mdir obj_dir

./obj_dir/Vtb_sim_db > sim.log
cat sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sim/tb_sim_db.sv */
/*
 * trace driven testbench of the speed sensor simulator top level
 * local bus read and write tasks, channel edge measurement, result counts
 */
`default_nettype none

`include "tacho_settings.svh"

module tb_sim_db;
  timeunit 1ns;
  timeprecision 100ps;

  localparam string TRACE_FILE = "sim/tacho_trace.txt";
  localparam int    BUS_HOLD   = 6;    // strobe low time in cycles
  localparam int    OE_LIMIT   = 10;
  localparam int    EDGE_LIMIT = 100;  // free running edge wait
  localparam int    WINDOW     = 200;  // pulse counting window

  logic                    W_clk;
  logic                    W_reset_n;
  logic [`BUS_ADDR_W-1:0]  la;
  logic [`BUS_DATA_W-1:0]  ld_in;
  logic                    lcs_n;
  logic                    lrd_n;
  logic                    lwr_n;
  logic [`BUS_DATA_W-1:0]  ld_out;
  logic                    ld_oe;
  logic [`TACHO_CH-1:0]    spd_ch;

  string test_name;
  bit    in_test;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;

  sim_db_top sim_db_top_inst (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .la        (la),
    .ld_in     (ld_in),
    .lcs_n     (lcs_n),
    .lrd_n     (lrd_n),
    .lwr_n     (lwr_n),
    .ld_out    (ld_out),
    .ld_oe     (ld_oe),
    .spd_ch    (spd_ch)
  );

  initial
  begin
    W_clk = 1'b0;
    forever #5 W_clk = ~W_clk;
  end

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch %s %s expected %0h actual %0h", test_name, what, exp, act);
    test_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s: %s", test_name, msg);
    test_errors++;
  endtask

  // one result line per finished test
  task automatic close_test();
    if (in_test)
    begin
      tests_run++;
      if (test_errors == 0)
        $display("test %s: ok", test_name);
      else
      begin
        tests_failed++;
        $display("test %s: %0d errors", test_name, test_errors);
      end
    end
    total_errors += test_errors;
    test_errors = 0;
    in_test = 0;
  endtask

  // ------------------------------
  // local bus cycles, inputs change on falling edges
  task automatic bus_write(input logic [`BUS_ADDR_W-1:0] addr,
                           input logic [`BUS_DATA_W-1:0] data);
    @(negedge W_clk);
    la    = addr;
    ld_in = data;
    lcs_n = 1'b0;
    @(negedge W_clk);
    lwr_n = 1'b0;
    repeat (BUS_HOLD) @(negedge W_clk);
    lwr_n = 1'b1;
    lcs_n = 1'b1;
  endtask

  task automatic bus_read(input logic [`BUS_ADDR_W-1:0] addr,
                          input logic [`BUS_DATA_W-1:0] exp);
    logic [`BUS_DATA_W-1:0] got;
    logic                   oe_seen;
    int                     wait_cyc;
    @(negedge W_clk);
    la    = addr;
    lcs_n = 1'b0;
    @(negedge W_clk);
    lrd_n = 1'b0;
    repeat (BUS_HOLD) @(negedge W_clk);
    got     = ld_out;  // still inside the strobe
    oe_seen = ld_oe;
    lrd_n   = 1'b1;
    lcs_n   = 1'b1;
    if (got !== exp)
      report_mismatch($sformatf("read %h", addr), 32'(exp), 32'(got));
    if (oe_seen !== 1'b1)
      report_problem($sformatf("ld_oe stayed low during the read of %h", addr));
    wait_cyc = 0;
    while (ld_oe !== 1'b0 && wait_cyc < OE_LIMIT)
    begin
      @(negedge W_clk);
      wait_cyc++;
    end
    if (ld_oe !== 1'b0)
      report_problem("timeout waiting for ld_oe to fall after a read");
  endtask

  // ------------------------------
  // edge measurement on one channel and its partner
  // period 0 means the channel must stay quiet while the partner toggles
  task automatic measure(input int ch, input int period, input int lag, input int pulses);
    logic [`TACHO_CH-1:0] prev;
    logic [`TACHO_CH-1:0] cur;
    int prt;
    int cyc;
    int limit;
    int rises_ch;
    int rises_prt;
    int first_ch;
    int second_ch;
    int first_prt;
    bit seen;
    prt       = ch ^ 1;
    rises_ch  = 0;
    rises_prt = 0;
    first_ch  = -1;
    second_ch = -1;
    first_prt = -1;
    seen      = 0;
    limit     = (period == 0 || pulses != 0) ? WINDOW : EDGE_LIMIT;
    cyc       = 0;
    @(negedge W_clk);
    prev = spd_ch;
    while (!seen && cyc < limit)
    begin
      @(negedge W_clk);
      cyc++;
      cur = spd_ch;
      if (cur[ch] && !prev[ch])
      begin
        rises_ch++;
        if (first_ch < 0)
          first_ch = cyc;
        else if (second_ch < 0)
          second_ch = cyc;
      end
      if (cur[prt] && !prev[prt])
      begin
        rises_prt++;
        if (first_ch >= 0 && first_prt < 0)
          first_prt = cyc;  // first partner edge after ours
      end
      prev = cur;
      if (period != 0 && pulses == 0 && second_ch >= 0 && first_prt >= 0)
        seen = 1;
    end
    if (period == 0)
    begin
      if (rises_ch != 0)
        report_mismatch($sformatf("ch%0d rises", ch), 32'd0, rises_ch);
      if (rises_prt == 0)
        report_problem($sformatf("channel %0d never toggled", prt));
    end
    else if (second_ch < 0 || first_prt < 0)
      report_problem($sformatf("timeout waiting for rising edges on channel %0d", ch));
    else
    begin
      if (second_ch - first_ch != period)
        report_mismatch($sformatf("ch%0d period", ch), period, second_ch - first_ch);
      if (first_prt - first_ch != lag)
        report_mismatch($sformatf("ch%0d lag", prt), lag, first_prt - first_ch);
      if (pulses != 0 && rises_ch != pulses)
        report_mismatch($sformatf("ch%0d pulses", ch), pulses, rises_ch);
      if (pulses != 0 && rises_prt != pulses)
        report_mismatch($sformatf("ch%0d pulses", prt), pulses, rises_prt);
    end
  endtask

  // one trace line, kind in the first column
  task automatic run_line(input string line);
    byte                    kind;
    logic [`BUS_ADDR_W-1:0] addr;
    logic [`BUS_DATA_W-1:0] data;
    int                     ch;
    int                     period;
    int                     lag;
    int                     pulses;
    int                     n;
    kind = (line.len() > 0) ? line.getc(0) : "#";
    case (kind)
      "T":
      begin
        close_test();
        n       = $sscanf(line, "T %s", test_name);
        in_test = 1;
      end
      "W":
      begin
        n = $sscanf(line, "W %h %h", addr, data);
        if (n == 2)
          bus_write(addr, data);
        else
          report_problem("malformed write line in the trace");
      end
      "R":
      begin
        n = $sscanf(line, "R %h %h", addr, data);
        if (n == 2)
          bus_read(addr, data);
        else
          report_problem("malformed read line in the trace");
      end
      "M":
      begin
        n = $sscanf(line, "M %h %h %h %h", ch, period, lag, pulses);
        if (n == 4 && ch >= 0 && ch < `TACHO_CH)
          measure(ch, period, lag, pulses);
        else
          report_problem("malformed measurement line in the trace");
      end
      default: ;  // comments and blank lines
    endcase
  endtask

  // ------------------------------
  initial
  begin
    int    fd;
    string line;
    la           = '0;
    ld_in        = '0;
    lcs_n        = 1'b1;
    lrd_n        = 1'b1;
    lwr_n        = 1'b1;
    W_reset_n    = 1'b0;
    in_test      = 0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(posedge W_clk);
    @(negedge W_clk);
    W_reset_n = 1'b1;

    test_name = "reset";
    in_test   = 1;
    if (ld_oe !== 1'b0)
      report_problem("ld_oe high after reset");
    if (spd_ch !== '0)
      report_mismatch("spd_ch", 32'd0, 32'(spd_ch));
    close_test();

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0)
    begin
      $display("cannot open the trace file %s", TRACE_FILE);
      total_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) != 0)
          run_line(line);
      end
      $fclose(fd);
      close_test();  // last test of the trace
    end

    $display("tests %0d, failing %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/sim_db_top.sv */
/*
 * speed sensor simulator top level
 * bus synchroniser, register file and tachometer pairs
 */
`default_nettype none

`include "tacho_settings.svh"

module sim_db_top
  import bus_pkg::*;
  import tacho_pkg::*;
(
  input  wire                      W_clk,
  input  wire                      W_reset_n,
  input  wire [`BUS_ADDR_W-1:0]    la,
  input  wire [`BUS_DATA_W-1:0]    ld_in,
  input  wire                      lcs_n,
  input  wire                      lrd_n,
  input  wire                      lwr_n,
  output logic [`BUS_DATA_W-1:0]   ld_out,
  output logic                     ld_oe,
  output logic [`TACHO_CH-1:0]     spd_ch
);

  bus_req_t                        req;
  pair_cfg_t [`TACHO_PAIRS-1:0]    cfg;
  pair_en_t  [`TACHO_PAIRS-1:0]    en;
  logic      [`TACHO_PAIRS-1:0]    load;
  logic      [`TACHO_PAIRS-1:0]    finished;

  local_bus_sync local_bus_sync_inst (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .la        (bus_addr_t'(la)),
    .ld_in     (ld_in),
    .lcs_n     (lcs_n),
    .lrd_n     (lrd_n),
    .lwr_n     (lwr_n),
    .req       (req)
  );

  tacho_regs tacho_regs_inst (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .req       (req),
    .finished  (finished),
    .ld_out    (ld_out),
    .ld_oe     (ld_oe),
    .cfg       (cfg),
    .en        (en),
    .load      (load)
  );

  // pair i drives channels 2i and 2i+1
  for (genvar i = 0; i < `TACHO_PAIRS; i++)
  begin : g_pair
    tacho_pair tacho_pair_inst (
      .W_clk     (W_clk),
      .W_reset_n (W_reset_n),
      .cfg       (cfg[i]),
      .en        (en[i]),
      .load      (load[i]),
      .ch        (spd_ch[2*i +: 2]),
      .finished  (finished[i])
    );
  end

endmodule

`default_nettype wire

/* rtl/tacho_pair.sv */
/*
 * two channel square wave generator
 * programmable phase lag, pulse limit and enable gating
 */
`default_nettype none

`include "tacho_settings.svh"

module tacho_pair
  import tacho_pkg::*;
(
  input  wire            W_clk,
  input  wire            W_reset_n,
  input  wire pair_cfg_t cfg,
  input  wire pair_en_t  en,
  input  wire            load,
  output logic [1:0]     ch,
  output logic           finished
);

  pair_cfg_t                  cfg_q;     // latched on load
  logic [`TACHO_WORD_W-1:0]   hp_last;
  logic [`TACHO_WORD_W-2:0]   lag_cnt;
  logic                       lag_on;    // lagging wave has started
  logic                       run;
  logic [1:0]                 step;
  logic [1:0]                 wave;      // [0] lead, [1] lag
  logic [1:0]                 done;
  logic                       ch1_w;
  logic                       ch2_w;

  assign hp_last = cfg_q.half_period - 1'b1;
  assign run     = (en.ch1 | en.ch2) & (cfg_q.half_period != '0);
  assign step    = {run & lag_on, run};

  // ------------------------------
  // lag delay, counts run cycles up to the programmed lag
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      lag_cnt <= '0;
      lag_on  <= 1'b0;
    end
    else if (load)
    begin
      lag_cnt <= '0;
      lag_on  <= (cfg.phase.lead.lag == '0);
    end
    else if (run && !lag_on)
    begin
      lag_cnt <= lag_cnt + 1'b1;
      if (lag_cnt + 1'b1 == cfg_q.phase.lead.lag)
        lag_on <= 1'b1;
    end
  end

  // load latches the new settings
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
      cfg_q <= '0;
    else if (load)
      cfg_q <= cfg;
  end

  // ------------------------------
  // lead and lag waves, same generator, lag one starts late
  for (genvar i = 0; i < 2; i++)
  begin : g_wave
    logic [`TACHO_WORD_W-1:0] hp_cnt;
    logic [`BUS_DATA_W-1:0]   pulses;  // completed high pulses
    logic                     w;

    always_ff @(posedge W_clk)
    begin
      if (!W_reset_n)
      begin
        hp_cnt <= '0;
        pulses <= '0;
        w      <= 1'b0;
      end
      else if (load)
      begin
        hp_cnt <= '0;
        pulses <= '0;
        w      <= 1'b0;
      end
      else if (step[i] && !done[i])
      begin
        if (hp_cnt == hp_last)
        begin
          hp_cnt <= '0;
          w      <= ~w;
          if (w)
            pulses <= pulses + 1'b1;  // falling edge ends a pulse
        end
        else
          hp_cnt <= hp_cnt + 1'b1;
      end
    end

    assign wave[i] = w;
    assign done[i] = cfg_q.limited && (pulses == cfg_q.pulse_num);
  end

  // lead flag swaps which channel gets the early wave
  assign ch1_w    = cfg_q.phase.lead.ch2_leads ? wave[1] : wave[0];
  assign ch2_w    = cfg_q.phase.lead.ch2_leads ? wave[0] : wave[1];
  assign ch       = {en.ch2 & ch2_w, en.ch1 & ch1_w};
  assign finished = done[1];  // lag wave ends last

endmodule

`default_nettype wire

/* rtl/tacho_regs.sv */
/*
 * register file of the 0x8xx region
 * address decode, read data, load pulses and pair config fan-out
 */
`default_nettype none

`include "tacho_settings.svh"

module tacho_regs
  import bus_pkg::*;
  import tacho_pkg::*;
(
  input  wire                                W_clk,
  input  wire                                W_reset_n,
  input  wire bus_req_t                      req,
  input  wire [`TACHO_PAIRS-1:0]             finished,
  output logic [`BUS_DATA_W-1:0]             ld_out,
  output logic                               ld_oe,
  output pair_cfg_t [`TACHO_PAIRS-1:0]       cfg,
  output pair_en_t  [`TACHO_PAIRS-1:0]       en,
  output logic [`TACHO_PAIRS-1:0]            load
);

  localparam int AW = `BUS_ADDR_W;
  localparam int NP = `TACHO_PAIRS;

  logic [AW-1:0]              addr;
  logic                       region_hit;
  logic [`BUS_DATA_W-1:0]     rdata;

  logic [NP-1:0]              mode_q;       // limited mode per pair
  logic [`TACHO_CH-1:0]       out_ctrl_q;   // channel enables
  logic [`TACHO_WORD_W-1:0]   freq_q  [NP];
  phase_word_u                phase_q [NP];
  logic [`BUS_DATA_W-1:0]     pulse_q [NP];

  function automatic logic [AW-1:0] pair_addr(input int base, input int p, input int stride);
    pair_addr = AW'(base + p * stride);
  endfunction

  assign addr       = req.addr;
  assign region_hit = (req.addr.region == `FPGA_REGION);
  assign ld_oe      = req.rd_active & region_hit;

  // ------------------------------
  // register writes
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      mode_q     <= '0;
      out_ctrl_q <= '0;
      load       <= '0;
      for (int p = 0; p < NP; p++)
      begin
        freq_q[p]  <= '0;
        phase_q[p] <= '0;
        pulse_q[p] <= '0;
      end
    end
    else
    begin
      load <= '0;  // single cycle strobe
      if (req.wr_pulse && region_hit)
      begin
        case (addr)
          `ADDR_MODE:     mode_q     <= req.wdata[NP-1:0];
          `ADDR_OUT_CTRL: out_ctrl_q <= req.wdata[`TACHO_CH-1:0];
          `ADDR_LOAD:     load       <= req.wdata[NP-1:0];  // not stored
          default: ;
        endcase
        for (int p = 0; p < NP; p++)
        begin
          if (addr == pair_addr(`ADDR_FREQ_BASE, p, `ADDR_WORD_STRIDE))
            freq_q[p][15:0] <= req.wdata;
          if (addr == pair_addr(`ADDR_FREQ_BASE + 2, p, `ADDR_WORD_STRIDE))
            freq_q[p][31:16] <= req.wdata;
          if (addr == pair_addr(`ADDR_PHASE_BASE, p, `ADDR_WORD_STRIDE))
            phase_q[p].half.lo <= req.wdata;
          if (addr == pair_addr(`ADDR_PHASE_BASE + 2, p, `ADDR_WORD_STRIDE))
            phase_q[p].half.hi <= req.wdata;
          if (addr == pair_addr(`ADDR_PULSE_BASE, p, `ADDR_PULSE_STRIDE))
            pulse_q[p] <= req.wdata;
        end
      end
    end
  end

  // ------------------------------
  // read mux
  always_comb
  begin
    rdata = '0;  // load register and holes read 0
    case (addr)
      `ADDR_VERSION:  rdata = `FPGA_VERSION;
      `ADDR_PAT_AAAA: rdata = 16'hAAAA;
      `ADDR_PAT_5555: rdata = 16'h5555;
      `ADDR_MODE:     rdata[NP-1:0] = mode_q;
      `ADDR_OUT_CTRL: rdata[`TACHO_CH-1:0] = out_ctrl_q;
      `ADDR_FINISHED: rdata[NP-1:0] = finished;
      default: ;
    endcase
    for (int p = 0; p < NP; p++)
    begin
      if (addr == pair_addr(`ADDR_FREQ_BASE, p, `ADDR_WORD_STRIDE))
        rdata = freq_q[p][15:0];
      if (addr == pair_addr(`ADDR_FREQ_BASE + 2, p, `ADDR_WORD_STRIDE))
        rdata = freq_q[p][31:16];
      if (addr == pair_addr(`ADDR_PHASE_BASE, p, `ADDR_WORD_STRIDE))
        rdata = phase_q[p].half.lo;
      if (addr == pair_addr(`ADDR_PHASE_BASE + 2, p, `ADDR_WORD_STRIDE))
        rdata = phase_q[p].half.hi;
      if (addr == pair_addr(`ADDR_PULSE_BASE, p, `ADDR_PULSE_STRIDE))
        rdata = pulse_q[p];
    end
  end

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
      ld_out <= '0;
    else if (req.rd_pulse && region_hit)
      ld_out <= rdata;  // held until the next read
  end

  // config fan-out to the pair generators
  for (genvar p = 0; p < NP; p++)
  begin : g_cfg
    assign cfg[p].half_period = freq_q[p];
    assign cfg[p].phase       = phase_q[p];
    assign cfg[p].pulse_num   = pulse_q[p];
    assign cfg[p].limited     = mode_q[p];
    assign en[p]              = pair_en_t'(out_ctrl_q[2*p +: 2]);
  end

endmodule

`default_nettype wire

/* rtl/local_bus_sync.sv */
/*
 * local bus strobe synchroniser
 * falling edge detect of rd and wr, forms bus requests
 */
`default_nettype none

`include "tacho_settings.svh"

module local_bus_sync
  import bus_pkg::*;
(
  input  wire                    W_clk,
  input  wire                    W_reset_n,
  input  wire bus_addr_t         la,
  input  wire [`BUS_DATA_W-1:0]  ld_in,
  input  wire                    lcs_n,
  input  wire                    lrd_n,
  input  wire                    lwr_n,
  output bus_req_t               req
);

  // [0] first stage, [1] second stage, [2] previous second stage
  logic [1:0] cs_sr;
  logic [2:0] rd_sr;
  logic [2:0] wr_sr;

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      cs_sr <= '1;  // strobes idle high
      rd_sr <= '1;
      wr_sr <= '1;
    end
    else
    begin
      cs_sr <= {cs_sr[0], lcs_n};
      rd_sr <= {rd_sr[1:0], lrd_n};
      wr_sr <= {wr_sr[1:0], lwr_n};
    end
  end

  // host holds address and data steady around the strobes
  assign req.addr      = la;
  assign req.wdata     = ld_in;
  assign req.rd_pulse  = ~cs_sr[1] & ~rd_sr[1] & rd_sr[2];
  assign req.wr_pulse  = ~cs_sr[1] & ~wr_sr[1] & wr_sr[2];
  assign req.rd_active = ~cs_sr[1] & ~rd_sr[1];

endmodule

`default_nettype wire

/* rtl/tacho_pkg.sv */
/*
 * tachometer pair types
 * phase word union, pair configuration and channel enables
 */
`default_nettype none

`include "tacho_settings.svh"

package tacho_pkg;

  // phase word as the host writes it
  typedef struct packed {
    logic [`BUS_DATA_W-1:0] hi;
    logic [`BUS_DATA_W-1:0] lo;
  } phase_halves_t;

  // phase word as the generator reads it
  typedef struct packed {
    logic                     ch2_leads;  // 1 - channel 2 leads
    logic [`TACHO_WORD_W-2:0] lag;        // lag in clock cycles
  } phase_lead_t;

  typedef union packed {
    phase_halves_t half;
    phase_lead_t   lead;
  } phase_word_u;

  // ------------------------------
  // per pair configuration
  typedef struct packed {
    logic [`TACHO_WORD_W-1:0] half_period;  // cycles between toggles
    phase_word_u              phase;
    logic [`BUS_DATA_W-1:0]   pulse_num;    // pulse limit
    logic                     limited;      // 1 - stop after pulse_num
  } pair_cfg_t;

  typedef struct packed {
    logic ch2;
    logic ch1;
  } pair_en_t;

endpackage

`default_nettype wire

/* rtl/bus_pkg.sv */
/*
 * local bus transport types
 * address view and synchronised bus request
 */
`default_nettype none

`include "tacho_settings.svh"

package bus_pkg;

  // address split into device region and register offset
  typedef struct packed {
    logic [`BUS_ADDR_W-9:0] region;
    logic [7:0]             offset;
  } bus_addr_t;

  // one request per strobe edge, address and data ride along
  typedef struct packed {
    bus_addr_t              addr;
    logic [`BUS_DATA_W-1:0] wdata;
    logic                   rd_pulse;   // falling edge of rd, cs low
    logic                   wr_pulse;   // falling edge of wr, cs low
    logic                   rd_active;  // cs and rd both low
  } bus_req_t;

endpackage

`default_nettype wire

/* include/tacho_settings.svh */
/*
 * bus widths, tachometer pair count and version word
 * register address map of the 0x8xx local bus region
 */
`ifndef TACHO_SETTINGS_SVH
`define TACHO_SETTINGS_SVH

`define BUS_ADDR_W        12
`define BUS_DATA_W        16
`define TACHO_PAIRS       2                  // 1 to 4
`define TACHO_CH          (2 * `TACHO_PAIRS)
`define TACHO_WORD_W      32                 // frequency and phase words

`define FPGA_REGION       4'h8
`define FPGA_VERSION      16'hB616

// register map
`define ADDR_VERSION      12'h800
`define ADDR_PAT_AAAA     12'h802
`define ADDR_PAT_5555     12'h804
`define ADDR_MODE         12'h810            // limited-pulse mode, one bit per pair
`define ADDR_OUT_CTRL     12'h812            // output enables, one bit per channel
`define ADDR_LOAD         12'h814            // write only, one bit per pair
`define ADDR_FREQ_BASE    12'h820            // low half, high half at +2
`define ADDR_PHASE_BASE   12'h840            // low half, high half at +2
`define ADDR_PULSE_BASE   12'h860
`define ADDR_FINISHED     12'h870            // read only
`define ADDR_WORD_STRIDE  4                  // per pair, freq and phase
`define ADDR_PULSE_STRIDE 2                  // per pair, pulse count

`endif
